/* vlog.f */
+incdir+bench
src/csr_pkg.sv
src/csr_access_ctrl.sv
src/csr_machine_regs.sv
src/csr_mvu_regs.sv
src/rv32_csr_file.sv
bench/csr_tb.sv

/* bench/csr_tb_table.svh */
`ifndef CSR_TB_TABLE_SVH
`define CSR_TB_TABLE_SVH

// Row fields in order are test, op, addr, wdata, random wdata, trap,
// irq {mvu,ext,timer,soft}, counter enable, check rdata, expect exception,
// mcycle kind (1 capture, 2 compare)
typedef struct packed {
    logic [3:0]        test;
    csr_pkg::csr_op_e  op;
    logic [11:0]       addr;
    logic [31:0]       wdata;
    logic              rnd;
    logic              trap;
    logic [3:0]        irq;
    logic              en;
    logic              chk;
    logic              exc;
    logic [1:0]        kind;
} row_t;

localparam int NUM_ROWS = 48;

localparam row_t ROW_TABLE [NUM_ROWS] = '{
    '{1, csr_pkg::SET,        12'h305, 32'h0000_0000, 0, 0, 4'h0, 0, 1, 0, 0}, // Boot mtvec
    '{2, csr_pkg::READ_WRITE, 12'hF20, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{2, csr_pkg::READ_WRITE, 12'hF21, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{2, csr_pkg::READ_WRITE, 12'hF22, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{2, csr_pkg::READ_WRITE, 12'hF23, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{2, csr_pkg::READ_WRITE, 12'hF24, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{2, csr_pkg::READ_WRITE, 12'hF25, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{2, csr_pkg::READ_WRITE, 12'hF26, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{2, csr_pkg::READ_WRITE, 12'hF27, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{2, csr_pkg::SET,        12'hF20, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{2, csr_pkg::CLEAR,      12'hF21, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{2, csr_pkg::SET,        12'hF22, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{2, csr_pkg::CLEAR,      12'hF23, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{2, csr_pkg::SET,        12'hF24, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{2, csr_pkg::CLEAR,      12'hF25, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{2, csr_pkg::SET,        12'hF26, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{2, csr_pkg::CLEAR,      12'hF27, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{3, csr_pkg::READ_WRITE, 12'h304, 32'hFFFF_FFFF, 0, 0, 4'h0, 0, 1, 0, 0},
    '{3, csr_pkg::READ_WRITE, 12'h305, 32'h1234_5677, 0, 0, 4'h0, 0, 1, 0, 0}, // Vector mode
    '{3, csr_pkg::READ_WRITE, 12'h305, 32'h8000_00FE, 0, 0, 4'h0, 0, 1, 0, 0},
    '{3, csr_pkg::READ_WRITE, 12'h341, 32'h0000_1003, 0, 0, 4'h0, 0, 1, 0, 0},
    '{3, csr_pkg::SET,        12'h304, 32'h0000_0000, 0, 0, 4'h0, 0, 1, 0, 0},
    '{3, csr_pkg::SET,        12'h305, 32'h0000_0000, 0, 0, 4'h0, 0, 1, 0, 0},
    '{3, csr_pkg::SET,        12'h341, 32'h0000_0000, 0, 0, 4'h0, 0, 1, 0, 0},
    '{4, csr_pkg::READ_WRITE, 12'h7C0, 32'hFFFF_FFFF, 0, 0, 4'h0, 0, 1, 1, 0}, // Unknown
    '{4, csr_pkg::SET,        12'h304, 32'h0000_0000, 0, 0, 4'h0, 0, 1, 0, 0},
    '{5, csr_pkg::READ_WRITE, 12'h300, 32'h0000_0008, 0, 0, 4'h0, 0, 1, 0, 0}, // mie on
    '{5, csr_pkg::NONE,       12'h300, 32'h0000_0000, 0, 1, 4'h0, 0, 0, 0, 0}, // Trap
    '{5, csr_pkg::SET,        12'h300, 32'h0000_0000, 0, 0, 4'h0, 0, 1, 0, 0},
    '{5, csr_pkg::SET,        12'h342, 32'h0000_0000, 0, 0, 4'h0, 0, 1, 0, 0},
    '{5, csr_pkg::MRET,       12'h300, 32'h0000_0000, 0, 0, 4'h0, 0, 0, 0, 0},
    '{5, csr_pkg::CLEAR,      12'h300, 32'h0000_0080, 0, 0, 4'h0, 0, 1, 0, 0}, // mpie off
    '{5, csr_pkg::MRET,       12'h300, 32'h0000_0000, 0, 0, 4'h0, 0, 0, 0, 0},
    '{5, csr_pkg::SET,        12'h300, 32'h0000_0000, 0, 0, 4'h0, 0, 1, 0, 0},
    '{6, csr_pkg::NONE,       12'h000, 32'h0000_0000, 0, 0, 4'hA, 1, 0, 0, 0},
    '{6, csr_pkg::SET,        12'h344, 32'h0000_0000, 0, 0, 4'h5, 1, 1, 0, 0},
    '{6, csr_pkg::SET,        12'h344, 32'h0000_0000, 0, 0, 4'h0, 1, 1, 0, 0},
    '{6, csr_pkg::SET,        12'hB00, 32'h0000_0000, 0, 0, 4'h0, 1, 0, 0, 1},
    '{6, csr_pkg::NONE,       12'h000, 32'h0000_0000, 0, 0, 4'h0, 1, 0, 0, 0},
    '{6, csr_pkg::NONE,       12'h000, 32'h0000_0000, 0, 0, 4'h0, 1, 0, 0, 0},
    '{6, csr_pkg::SET,        12'hB00, 32'h0000_0000, 0, 0, 4'h0, 1, 0, 0, 2},
    '{6, csr_pkg::SET,        12'hB00, 32'h0000_0000, 0, 0, 4'h0, 0, 0, 0, 1}, // Counter off
    '{6, csr_pkg::NONE,       12'h000, 32'h0000_0000, 0, 0, 4'h0, 0, 0, 0, 0},
    '{6, csr_pkg::SET,        12'hB00, 32'h0000_0000, 0, 0, 4'h0, 0, 0, 0, 2},
    '{7, csr_pkg::READ_WRITE, 12'hF21, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{7, csr_pkg::NONE,       12'h000, 32'h0000_0000, 0, 0, 4'h0, 0, 0, 0, 0},
    '{7, csr_pkg::READ_WRITE, 12'hF22, 32'h0000_0000, 1, 0, 4'h0, 0, 1, 0, 0},
    '{7, csr_pkg::NONE,       12'h000, 32'h0000_0000, 0, 0, 4'h0, 0, 0, 0, 0}
};

`endif

/* bench/csr_tb.sv */
module csr_tb;
    timeunit 1ns;
    timeprecision 100ps;

    `include "csr_tb_table.svh"

    localparam logic [31:0] BOOT_ADDR = 32'h0000_8000;
    localparam int          MAX_CYCLES = 200;    // Watchdog limit

    logic                clk = 1'b0;
    logic                rst_n;
    csr_pkg::csr_req_t   req;
    logic [31:0]         rdata;
    csr_pkg::exception_t exc;
    logic                irq, time_irq, ipi, mvu_irq;
    logic                trap_valid, cnt_en;
    logic [31:0]         pc, cause, epc;
    csr_pkg::mvu_cfg_t   cfg;
    logic                start;

    logic [31:0] model [0:4095];    // Expected CSR contents by address
    integer      seed = 32'he302;
    int          errors, test_errs, passed, failed;
    int          en_acc, en_mark;   // Enabled counter edges
    logic [31:0] cyc_ref;
    logic        prev_cd;           // Last row stored countdown

    always #20 clk = ~clk;

    rv32_csr_file i_rv32_csr_file (
        .clk                  (clk),
        .rst_n                (rst_n),
        .csr_req_i            (req),
        .csr_rdata_o          (rdata),
        .csr_exception_o      (exc),
        .irq_i                (irq),
        .time_irq_i           (time_irq),
        .ipi_i                (ipi),
        .mvu_irq_i            (mvu_irq),
        .trap_valid_i         (trap_valid),
        .pc_i                 (pc),
        .cause_i              (cause),
        .enable_cycle_count_i (cnt_en),
        .boot_addr_i          (BOOT_ADDR),
        .csr_epc_o            (epc),
        .mvu_cfg_o            (cfg),
        .mvu_start_o          (start)
    );

    // Stored value after a write, per CSR write rule
    function automatic logic [31:0] store_rule(input logic [11:0] a, input logic [31:0] v);
        case (a)
            12'h300: return v & 32'h7FFE_1FEE;      // sd, xs, fs, upie, uie tied low
            12'h304: return v & 32'h0001_0888;      // MSIP, MTIP, MEIP, MVIP
            12'h305: return v[0] ? {v[31:8], 8'h01} : {v[31:2], 2'b00};
            12'h341: return {v[31:1], 1'b0};
            12'hF20: return v & 32'h3;
            12'hF21: return v & 32'h1FFF_FFFF;
            12'hF22, 12'hF23, 12'hF24: return v & 32'h3F;
            12'hF25: return v & 32'h1FF;
            12'hF26, 12'hF27: return v & 32'h7FFF;
            default: return v;
        endcase
    endfunction

    task automatic check(input string name, input logic [95:0] got, input logic [95:0] exp);
        assert (got === exp)
        else begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    // Applies one access and checks it at the falling edge
    task automatic run_row(input row_t r);
        logic [31:0] wd, old, nv, pc_v, cause_v;
        logic        legal;
        wd      = r.rnd ? $random(seed) : r.wdata;
        pc_v    = $random(seed);
        cause_v = $random(seed);
        @(posedge clk);
        req        <= '{addr: r.addr, op: r.op, wdata: wd};
        trap_valid <= r.trap;
        pc         <= pc_v;
        cause      <= cause_v;
        {mvu_irq, irq, time_irq, ipi} <= r.irq;
        cnt_en     <= r.en;
        @(negedge clk);
        old = model[r.addr];
        if (r.chk)
            check("csr_rdata_o", rdata, r.exc ? 32'h0 : old);
        check("csr_exception_o.valid", exc.valid, r.exc);
        check("csr_exception_o.cause", exc.cause, r.exc ? 32'd2 : 32'd0);
        check("mvu_start_o", start, prev_cd);
        check("csr_epc_o", epc, model[12'h341]);
        check("mvu_cfg_o", cfg, {model[12'hF20][1:0], model[12'hF21][28:0],
            model[12'hF22][5:0], model[12'hF23][5:0], model[12'hF24][5:0],
            model[12'hF25][8:0], model[12'hF26][14:0], model[12'hF27][14:0]});
        if (r.kind == 2'd1) begin
            cyc_ref = rdata;
            en_mark = en_acc;
        end
        if (r.kind == 2'd2)
            check("csr_rdata_o (mcycle)", rdata, cyc_ref + 32'(en_acc - en_mark));
        // Model update
        legal = (r.op inside {csr_pkg::READ_WRITE, csr_pkg::SET, csr_pkg::CLEAR}) && !r.exc;
        nv = (r.op == csr_pkg::SET) ? (old | wd) : (r.op == csr_pkg::CLEAR) ? (old & ~wd) : wd;
        if (legal && r.addr != 12'h344 && r.addr != 12'hB00)
            model[r.addr] = store_rule(r.addr, nv);
        if (r.trap) begin
            model[12'h341]    = pc_v;
            model[12'h342]    = cause_v;
            model[12'h300][7] = model[12'h300][3];   // mpie from mie
            model[12'h300][3] = 1'b0;
        end else if (r.op == csr_pkg::MRET) begin
            model[12'h300][3] = model[12'h300][7];
            model[12'h300][7] = 1'b1;
        end
        model[12'h344] = (32'(r.irq[0]) << 3) | (32'(r.irq[1]) << 7) |
                         (32'(r.irq[2]) << 11) | (32'(r.irq[3]) << 16);
        prev_cd = legal && (r.addr == 12'hF21);
        if (r.kind == 2'd0)
            en_acc += r.en;    // mcycle write beats the increment
    endtask

    initial begin : watchdog
        for (int c = 0; c < MAX_CYCLES; c++)
            @(posedge clk);
        $display("Timeout, sequence still running after %0d cycles", MAX_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        req = '0;
        {irq, time_irq, ipi, mvu_irq, trap_valid, cnt_en} = '0;
        pc = '0;
        cause = '0;
        foreach (model[i])
            model[i] = '0;
        model[12'h305] = BOOT_ADDR + 32'h40;  // Loaded on first edge out of reset
        errors = 0;
        test_errs = 0;
        passed = 0;
        failed = 0;
        en_acc = 0;
        en_mark = 0;
        prev_cd = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(ROW_TABLE[i]);
            if (i == NUM_ROWS - 1 || ROW_TABLE[i+1].test != ROW_TABLE[i].test) begin
                $display("test %0d %s, %0d errors", ROW_TABLE[i].test,
                         test_errs == 0 ? "passed" : "failed", test_errs);
                if (test_errs == 0)
                    passed++;
                else
                    failed++;
                test_errs = 0;
            end
        end
        $display("tests passed %0d, failed %0d, failed checks %0d", passed, failed, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* src/rv32_csr_file.sv */
module rv32_csr_file (
    input  logic                     clk,
    input  logic                     rst_n,
    // CSR access port
    input  csr_pkg::csr_req_t        csr_req_i,
    output logic [csr_pkg::XLEN-1:0] csr_rdata_o,
    output csr_pkg::exception_t      csr_exception_o,
    // Interrupt lines
    input  logic                     irq_i,
    input  logic                     time_irq_i,
    input  logic                     ipi_i,
    input  logic                     mvu_irq_i,
    // Trap side
    input  logic                     trap_valid_i,
    input  logic [csr_pkg::XLEN-1:0] pc_i,
    input  logic [csr_pkg::XLEN-1:0] cause_i,
    input  logic                     enable_cycle_count_i,
    input  logic [csr_pkg::XLEN-1:0] boot_addr_i,
    output logic [csr_pkg::XLEN-1:0] csr_epc_o,
    // MVU side
    output csr_pkg::mvu_cfg_t        mvu_cfg_o,
    output logic                     mvu_start_o
);

    csr_pkg::csr_wr_t  wr;          // Shared by both banks
    csr_pkg::csr_rsp_t mach_rsp;
    csr_pkg::csr_rsp_t mvu_rsp;
    logic              mret;

    csr_access_ctrl i_csr_access_ctrl (
        .csr_req_i       (csr_req_i),
        .mach_rsp_i      (mach_rsp),
        .mvu_rsp_i       (mvu_rsp),
        .wr_o            (wr),
        .mret_o          (mret),
        .csr_rdata_o     (csr_rdata_o),
        .csr_exception_o (csr_exception_o)
    );

    csr_machine_regs i_csr_machine_regs (
        .clk                  (clk),
        .rst_n                (rst_n),
        .wr_i                 (wr),
        .mret_i               (mret),
        .trap_valid_i         (trap_valid_i),
        .pc_i                 (pc_i),
        .cause_i              (cause_i),
        .irq_i                (irq_i),
        .time_irq_i           (time_irq_i),
        .ipi_i                (ipi_i),
        .mvu_irq_i            (mvu_irq_i),
        .enable_cycle_count_i (enable_cycle_count_i),
        .boot_addr_i          (boot_addr_i),
        .rsp_o                (mach_rsp),
        .csr_epc_o            (csr_epc_o)
    );

    csr_mvu_regs i_csr_mvu_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_i        (wr),
        .rsp_o       (mvu_rsp),
        .mvu_cfg_o   (mvu_cfg_o),
        .mvu_start_o (mvu_start_o)
    );

endmodule

/* src/csr_mvu_regs.sv */
module csr_mvu_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  csr_pkg::csr_wr_t  wr_i,          // Address also drives the read
    output csr_pkg::csr_rsp_t rsp_o,
    output csr_pkg::mvu_cfg_t mvu_cfg_o,     // Live job configuration
    output logic              mvu_start_o    // Kicks off the MVU job
);

    csr_pkg::mvu_cfg_t cfg_q, cfg_d;
    logic              start_q;
    logic              countdown_wr;

    // ========================================================================
    // Read port, fields zero extended
    // ========================================================================
    always_comb begin
        rsp_o.hit   = 1'b1;
        rsp_o.rdata = '0;
        case (csr_pkg::csr_addr_e'(wr_i.addr))
            csr_pkg::CSR_MVU_MUL_MODE:   rsp_o.rdata = csr_pkg::XLEN'(cfg_q.mul_mode);
            csr_pkg::CSR_MVU_COUNTDOWN:  rsp_o.rdata = csr_pkg::XLEN'(cfg_q.countdown);
            csr_pkg::CSR_MVU_WPRECISION: rsp_o.rdata = csr_pkg::XLEN'(cfg_q.wprecision);
            csr_pkg::CSR_MVU_IPRECISION: rsp_o.rdata = csr_pkg::XLEN'(cfg_q.iprecision);
            csr_pkg::CSR_MVU_OPRECISION: rsp_o.rdata = csr_pkg::XLEN'(cfg_q.oprecision);
            csr_pkg::CSR_MVU_WBASEADDR:  rsp_o.rdata = csr_pkg::XLEN'(cfg_q.wbaseaddr);
            csr_pkg::CSR_MVU_IBASEADDR:  rsp_o.rdata = csr_pkg::XLEN'(cfg_q.ibaseaddr);
            csr_pkg::CSR_MVU_OBASEADDR:  rsp_o.rdata = csr_pkg::XLEN'(cfg_q.obaseaddr);
            default:                     rsp_o.hit   = 1'b0;
        endcase
    end

    // ========================================================================
    // Write port, only field width is kept
    // ========================================================================
    always_comb begin
        cfg_d = cfg_q;
        if (wr_i.we) begin
            case (csr_pkg::csr_addr_e'(wr_i.addr))
                csr_pkg::CSR_MVU_MUL_MODE:   cfg_d.mul_mode   = wr_i.wdata[csr_pkg::MUL_MODE_W-1:0];
                csr_pkg::CSR_MVU_COUNTDOWN:  cfg_d.countdown  = wr_i.wdata[csr_pkg::COUNTDOWN_W-1:0];
                csr_pkg::CSR_MVU_WPRECISION: cfg_d.wprecision = wr_i.wdata[csr_pkg::PREC_W-1:0];
                csr_pkg::CSR_MVU_IPRECISION: cfg_d.iprecision = wr_i.wdata[csr_pkg::PREC_W-1:0];
                csr_pkg::CSR_MVU_OPRECISION: cfg_d.oprecision = wr_i.wdata[csr_pkg::PREC_W-1:0];
                csr_pkg::CSR_MVU_WBASEADDR:  cfg_d.wbaseaddr  = wr_i.wdata[csr_pkg::WBASE_W-1:0];
                csr_pkg::CSR_MVU_IBASEADDR:  cfg_d.ibaseaddr  = wr_i.wdata[csr_pkg::DBASE_W-1:0];
                csr_pkg::CSR_MVU_OBASEADDR:  cfg_d.obaseaddr  = wr_i.wdata[csr_pkg::DBASE_W-1:0];
                default:                     ;   // Machine bank
            endcase
        end
    end

    // Start only on a real countdown write
    assign countdown_wr = wr_i.we && (wr_i.addr == csr_pkg::CSR_MVU_COUNTDOWN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q   <= '0;
            start_q <= 1'b0;
        end else begin
            cfg_q   <= cfg_d;
            start_q <= countdown_wr;   // Pulse in the cycle after the store
        end
    end

    assign mvu_cfg_o   = cfg_q;
    assign mvu_start_o = start_q;

    // Core programs one job at a time, no back to back countdown writes
    start_one_shot: assert property (@(posedge clk) disable iff (!rst_n)
        mvu_start_o |=> !mvu_start_o)
        else $error("mvu_start_o high in two consecutive cycles");

endmodule

/* src/csr_machine_regs.sv */
module csr_machine_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  csr_pkg::csr_wr_t         wr_i,            // Address also drives the read
    input  logic                     mret_i,
    input  logic                     trap_valid_i,    // One strobe per trap
    input  logic [csr_pkg::XLEN-1:0] pc_i,            // PC of the trapping instruction
    input  logic [csr_pkg::XLEN-1:0] cause_i,
    input  logic                     irq_i,           // External
    input  logic                     time_irq_i,
    input  logic                     ipi_i,           // Software
    input  logic                     mvu_irq_i,
    input  logic                     enable_cycle_count_i,
    input  logic [csr_pkg::XLEN-1:0] boot_addr_i,
    output csr_pkg::csr_rsp_t        rsp_o,
    output logic [csr_pkg::XLEN-1:0] csr_epc_o
);

    csr_pkg::mstatus_u        mstatus_q, mstatus_d;
    logic [csr_pkg::XLEN-1:0] mie_q, mie_d;
    logic [csr_pkg::XLEN-1:0] mip_q;
    logic [csr_pkg::XLEN-1:0] mtvec_q, mtvec_d;
    logic [csr_pkg::XLEN-1:0] mepc_q, mepc_d;
    logic [csr_pkg::XLEN-1:0] mcause_q, mcause_d;
    logic [63:0]              mcycle_q, mcycle_d;
    logic                     mtvec_load_q;    // High for the first cycle out of reset

    // ========================================================================
    // Read port
    // ========================================================================
    always_comb begin
        rsp_o.hit   = 1'b1;
        rsp_o.rdata = '0;
        case (csr_pkg::csr_addr_e'(wr_i.addr))
            csr_pkg::CSR_MSTATUS: rsp_o.rdata = mstatus_q.raw;
            csr_pkg::CSR_MISA:    rsp_o.rdata = csr_pkg::ISA_CODE;
            csr_pkg::CSR_MIE:     rsp_o.rdata = mie_q;
            csr_pkg::CSR_MTVEC:   rsp_o.rdata = mtvec_q;
            csr_pkg::CSR_MEPC:    rsp_o.rdata = mepc_q;
            csr_pkg::CSR_MCAUSE:  rsp_o.rdata = mcause_q;
            csr_pkg::CSR_MIP:     rsp_o.rdata = mip_q;
            csr_pkg::CSR_MCYCLE:  rsp_o.rdata = mcycle_q[31:0];
            csr_pkg::CSR_MCYCLEH: rsp_o.rdata = mcycle_q[63:32];
            csr_pkg::CSR_MARCHID: rsp_o.rdata = csr_pkg::MARCHID;
            csr_pkg::CSR_MHARTID: rsp_o.rdata = csr_pkg::HART_ID;
            default:              rsp_o.hit   = 1'b0;   // Not ours
        endcase
    end

    // ========================================================================
    // Next state
    // ========================================================================
    always_comb begin
        mstatus_d = mstatus_q;
        mie_d     = mie_q;
        mepc_d    = mepc_q;
        mcause_d  = mcause_q;
        mtvec_d   = mtvec_load_q ? boot_addr_i + csr_pkg::MTVEC_BOOT_OFFSET : mtvec_q;
        mcycle_d  = enable_cycle_count_i ? mcycle_q + 64'd1 : mcycle_q;

        if (wr_i.we) begin
            case (csr_pkg::csr_addr_e'(wr_i.addr))
                csr_pkg::CSR_MSTATUS: mstatus_d.raw = wr_i.wdata;
                csr_pkg::CSR_MIE:     mie_d = wr_i.wdata & csr_pkg::MIE_MASK;
                csr_pkg::CSR_MTVEC: begin
                    // Vector mode needs a 256 byte aligned table
                    if (wr_i.wdata[0])
                        mtvec_d = {wr_i.wdata[31:8], 7'b0, 1'b1};
                    else
                        mtvec_d = {wr_i.wdata[31:2], 2'b00};
                end
                csr_pkg::CSR_MEPC:    mepc_d   = {wr_i.wdata[31:1], 1'b0};
                csr_pkg::CSR_MCAUSE:  mcause_d = wr_i.wdata;
                csr_pkg::CSR_MCYCLE:  mcycle_d = {mcycle_q[63:32], wr_i.wdata};  // Beats the increment
                csr_pkg::CSR_MCYCLEH: mcycle_d = {wr_i.wdata, mcycle_q[31:0]};
                default:              ;   // Read-only or MVU bank
            endcase
        end

        // Trap stack, trap has priority
        if (trap_valid_i) begin
            mstatus_d.fields.mpie = mstatus_q.fields.mie;
            mstatus_d.fields.mie  = 1'b0;
            mepc_d                = pc_i;
            mcause_d              = cause_i;
        end else if (mret_i) begin
            mstatus_d.fields.mie  = mstatus_q.fields.mpie;
            mstatus_d.fields.mpie = 1'b1;
        end

        // No U mode, no FP, no extension state
        mstatus_d.fields.sd   = 1'b0;
        mstatus_d.fields.xs   = 2'b00;
        mstatus_d.fields.fs   = 2'b00;
        mstatus_d.fields.upie = 1'b0;
        mstatus_d.fields.uie  = 1'b0;
    end

    // ========================================================================
    // Registers
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q    <= '0;
            mie_q        <= '0;
            mip_q        <= '0;
            mtvec_q      <= '0;
            mepc_q       <= '0;
            mcause_q     <= '0;
            mcycle_q     <= '0;
            mtvec_load_q <= 1'b1;
        end else begin
            mstatus_q    <= mstatus_d;
            mie_q        <= mie_d;
            mtvec_q      <= mtvec_d;
            mepc_q       <= mepc_d;
            mcause_q     <= mcause_d;
            mcycle_q     <= mcycle_d;
            mtvec_load_q <= 1'b0;
            // Interrupt lines sampled once per cycle
            mip_q[csr_pkg::IRQ_M_SOFT]  <= ipi_i;
            mip_q[csr_pkg::IRQ_M_TIMER] <= time_irq_i;
            mip_q[csr_pkg::IRQ_M_EXT]   <= irq_i;
            mip_q[csr_pkg::IRQ_MVU]     <= mvu_irq_i;
        end
    end

    assign csr_epc_o = mepc_q;

    // Core never retires an mret while a trap is being taken
    trap_mret_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(trap_valid_i && mret_i))
        else $error("trap_valid_i and mret_i high in the same cycle");

endmodule

/* src/csr_access_ctrl.sv */
module csr_access_ctrl (
    input  csr_pkg::csr_req_t        csr_req_i,       // Access from the core
    input  csr_pkg::csr_rsp_t        mach_rsp_i,      // Machine bank answer
    input  csr_pkg::csr_rsp_t        mvu_rsp_i,       // MVU bank answer
    output csr_pkg::csr_wr_t         wr_o,            // Resolved write, both banks
    output logic                     mret_o,          // Return from machine trap
    output logic [csr_pkg::XLEN-1:0] csr_rdata_o,
    output csr_pkg::exception_t      csr_exception_o
);

    logic                     access;   // RW, set or clear this cycle
    logic                     hit;      // Some bank owns the address
    logic                     illegal;
    logic [csr_pkg::XLEN-1:0] rdata;    // Data of the owning bank

    // ========================================================================
    // Operation decode
    // ========================================================================
    always_comb begin
        access = 1'b0;
        mret_o = 1'b0;
        case (csr_req_i.op)
            csr_pkg::READ_WRITE,
            csr_pkg::SET,
            csr_pkg::CLEAR: access = 1'b1;
            csr_pkg::MRET:  mret_o = 1'b1;   // No read, no write
            default:        ;                // NONE is idle
        endcase
    end

    // ========================================================================
    // Read select and exception
    // ========================================================================
    assign hit     = mach_rsp_i.hit | mvu_rsp_i.hit;
    assign illegal = access & ~hit;          // Unknown address

    assign rdata = mach_rsp_i.hit ? mach_rsp_i.rdata :
                   mvu_rsp_i.hit  ? mvu_rsp_i.rdata  : '0;

    assign csr_rdata_o           = access ? rdata : '0;
    assign csr_exception_o.valid = illegal;
    assign csr_exception_o.cause = illegal ? csr_pkg::ILLEGAL_INSTR : '0;

    // ========================================================================
    // Write data
    // ========================================================================
    always_comb begin
        wr_o.we   = access & hit;            // Illegal access leaves state alone
        wr_o.addr = csr_req_i.addr;
        case (csr_req_i.op)
            csr_pkg::SET:   wr_o.wdata = rdata | csr_req_i.wdata;
            csr_pkg::CLEAR: wr_o.wdata = rdata & ~csr_req_i.wdata;
            default:        wr_o.wdata = csr_req_i.wdata;
        endcase
    end

    // Address maps of the two banks are disjoint
    bank_overlap: assert final (!(mach_rsp_i.hit && mvu_rsp_i.hit))
        else $error("both CSR banks claim address %h", csr_req_i.addr);

endmodule

/* src/csr_pkg.sv */
package csr_pkg;

    // ========================================================================
    // Widths and fixed values
    // ========================================================================
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    localparam logic [XLEN-1:0] ILLEGAL_INSTR     = 32'd2;    // mcause code
    localparam logic [XLEN-1:0] HART_ID           = 32'd0;
    localparam logic [XLEN-1:0] MARCHID           = 32'd1;
    localparam logic [XLEN-1:0] ISA_CODE          = 32'h4000_1100; // MXL=1, I and M
    localparam logic [XLEN-1:0] MTVEC_BOOT_OFFSET = 32'h40;

    // Interrupt pending bit positions
    localparam int IRQ_M_SOFT  = 3;
    localparam int IRQ_M_TIMER = 7;
    localparam int IRQ_M_EXT   = 11;
    localparam int IRQ_MVU     = 16;   // Custom MVU line

    localparam logic [XLEN-1:0] MIE_MASK = (32'd1 << IRQ_M_SOFT) | (32'd1 << IRQ_M_TIMER) |
                                           (32'd1 << IRQ_M_EXT)  | (32'd1 << IRQ_MVU);

    // MVU field widths
    localparam int MUL_MODE_W  = 2;
    localparam int COUNTDOWN_W = 29;
    localparam int PREC_W      = 6;
    localparam int WBASE_W     = 9;
    localparam int DBASE_W     = 15;

    // ========================================================================
    // Addresses and operations
    // ========================================================================
    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_MSTATUS        = 12'h300,
        CSR_MISA           = 12'h301,
        CSR_MIE            = 12'h304,
        CSR_MTVEC          = 12'h305,
        CSR_MEPC           = 12'h341,
        CSR_MCAUSE         = 12'h342,
        CSR_MIP            = 12'h344,
        CSR_MCYCLE         = 12'hB00,
        CSR_MCYCLEH        = 12'hB80,
        CSR_MARCHID        = 12'hF12,
        CSR_MHARTID        = 12'hF14,
        // MVU block in register order
        CSR_MVU_MUL_MODE   = 12'hF20,
        CSR_MVU_COUNTDOWN  = 12'hF21,
        CSR_MVU_WPRECISION = 12'hF22,
        CSR_MVU_IPRECISION = 12'hF23,
        CSR_MVU_OPRECISION = 12'hF24,
        CSR_MVU_WBASEADDR  = 12'hF25,
        CSR_MVU_IBASEADDR  = 12'hF26,
        CSR_MVU_OBASEADDR  = 12'hF27
    } csr_addr_e;

    typedef enum logic [2:0] {
        NONE       = 3'd0,
        READ_WRITE = 3'd1,
        SET        = 3'd2,
        CLEAR      = 3'd3,
        MRET       = 3'd4
    } csr_op_e;

    // ========================================================================
    // Bundles
    // ========================================================================
    typedef struct packed {
        logic [CSR_ADDR_W-1:0] addr;
        csr_op_e               op;
        logic [XLEN-1:0]       wdata;
    } csr_req_t;

    typedef struct packed {
        logic                  we;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       wdata;   // Already merged for set/clear
    } csr_wr_t;

    typedef struct packed {
        logic            hit;
        logic [XLEN-1:0] rdata;
    } csr_rsp_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] cause;
    } exception_t;

    typedef struct packed {
        logic       sd;
        logic [7:0] wpri3;
        logic       tsr, tw, tvm, mxr, sum, mprv;
        logic [1:0] xs;
        logic [1:0] fs;
        logic [1:0] mpp;
        logic [1:0] wpri2;
        logic       spp, mpie, wpri1, spie, upie, mie, wpri0, sie, uie;
    } mstatus_fields_t;

    // Whole word for CSR access, fields for the trap stack
    typedef union packed {
        logic [XLEN-1:0] raw;
        mstatus_fields_t fields;
    } mstatus_u;

    typedef struct packed {
        logic [MUL_MODE_W-1:0]  mul_mode;
        logic [COUNTDOWN_W-1:0] countdown;
        logic [PREC_W-1:0]      wprecision;
        logic [PREC_W-1:0]      iprecision;
        logic [PREC_W-1:0]      oprecision;
        logic [WBASE_W-1:0]     wbaseaddr;
        logic [DBASE_W-1:0]     ibaseaddr;
        logic [DBASE_W-1:0]     obaseaddr;
    } mvu_cfg_t;

endpackage
